//--- verilog/kalman_pkg.sv
package kalman_pkg;

	localparam int HARMONICS_NUM = 4;
	localparam int HARM_IDX_WIDTH = $clog2(HARMONICS_NUM);
	localparam int Q_FRAC_BITS = 16; // Q2.16 samples, also the product shift

	// coefficient layout per harmonic
	localparam int COEF_PER_HARM = 4;
	localparam int COEF_COS = 0;
	localparam int COEF_SIN = 1;
	localparam int COEF_K1 = 2;
	localparam int COEF_K2 = 3;

	// state layout per harmonic
	localparam int STATE_PER_HARM = 2;
	localparam int STATE_X1 = 0;
	localparam int STATE_X2 = 1;

	localparam int COEF_ADDR_WIDTH = 4;
	localparam int STATE_ADDR_WIDTH = 3;
	localparam int APB_ADDR_WIDTH = 8;
	localparam int MAC_LATENCY = 2; // op_valid to res_valid

	typedef logic signed [17:0] sample_t;
	typedef logic signed [35:0] product_t;
	typedef logic [COEF_ADDR_WIDTH-1:0] coef_addr_t;
	typedef logic [STATE_ADDR_WIDTH-1:0] state_addr_t;
	typedef logic [HARM_IDX_WIDTH-1:0] harm_idx_t;
	typedef logic [APB_ADDR_WIDTH-1:0] apb_addr_t;

	localparam apb_addr_t REG_CTRL = 8'h00; // bit 0 start, bit 1 clear
	localparam apb_addr_t REG_STATUS = 8'h04; // bit 0 busy
	localparam apb_addr_t REG_SAMPLE = 8'h08;
	localparam apb_addr_t COEF_BASE = 8'h40; // word per coefficient, harmonic major

	typedef enum logic [2:0] {
		IDLE,
		PRED_RD,
		PRED_WAIT,
		ERR_WAIT,
		CORR_RD,
		CORR_WAIT,
		CLEAR,
		DONE
	} seq_state_e;

endpackage

//--- verilog/dp_ram.sv
`timescale 1ns/1ps

module dp_ram #(
	parameter int DEPTH = 16,
	parameter int WIDTH = 18
) (
	input logic clk_i,
	input logic we_i,
	input logic [$clog2(DEPTH)-1:0] waddr_i,
	input logic [WIDTH-1:0] wdata_i,
	input logic [$clog2(DEPTH)-1:0] raddr_i,
	output logic [WIDTH-1:0] rdata_o
);

	logic [WIDTH-1:0] mem_q [DEPTH];

	always_ff @(posedge clk_i) begin
		if (we_i)
			mem_q[waddr_i] <= wdata_i;
		rdata_o <= mem_q[raddr_i]; // read data shows up one cycle after the address
	end

	// a write to an unknown address would smear X over the whole array
	assert property (@(posedge clk_i) we_i |-> !$isunknown(waddr_i))
		else $error("dp_ram write with unknown address");

endmodule

//--- verilog/apb_host_port.sv
`timescale 1ns/1ps

module apb_host_port (
	input logic clk_i,
	input logic harmonics_rst,
	input logic psel_i,
	input logic penable_i,
	input logic pwrite_i,
	input kalman_pkg::apb_addr_t paddr_i,
	input logic [31:0] pwdata_i,
	output logic [31:0] prdata_o,
	output logic pready_o,
	output logic pslverr_o,
	input logic busy_i,
	output logic coef_we_o,
	output kalman_pkg::coef_addr_t coef_waddr_o,
	output kalman_pkg::sample_t coef_wdata_o,
	output kalman_pkg::sample_t sample_o,
	output logic start_o,
	output logic clear_o
);

	logic access;
	logic is_ctrl;
	logic is_status;
	logic is_sample;
	logic is_coef;
	logic mapped;
	logic wr_ok;

	assign access = psel_i & penable_i; // no wait states, every transfer ends here
	assign is_ctrl = paddr_i == kalman_pkg::REG_CTRL;
	assign is_status = paddr_i == kalman_pkg::REG_STATUS;
	assign is_sample = paddr_i == kalman_pkg::REG_SAMPLE;
	assign is_coef = (paddr_i >= kalman_pkg::COEF_BASE)
		&& (paddr_i < kalman_pkg::COEF_BASE
			+ 4 * kalman_pkg::HARMONICS_NUM * kalman_pkg::COEF_PER_HARM)
		&& (paddr_i[1:0] == 2'b00);
	assign mapped = is_ctrl | is_status | is_sample | is_coef;

	// status is read only so a write to it is simply dropped
	assign wr_ok = access & pwrite_i & mapped & ~is_status & ~busy_i;

	assign pready_o = 1'b1;
	assign pslverr_o = access & (~mapped | (pwrite_i & ~is_status & busy_i));

	assign coef_we_o = wr_ok & is_coef;
	assign coef_waddr_o = kalman_pkg::coef_addr_t'((paddr_i - kalman_pkg::COEF_BASE) >> 2);
	assign coef_wdata_o = pwdata_i[17:0];

	// single cycle pulses since the access phase lasts one cycle
	assign start_o = wr_ok & is_ctrl & pwdata_i[0];
	assign clear_o = wr_ok & is_ctrl & pwdata_i[1];

	always_ff @(posedge clk_i) begin
		if (wr_ok & is_sample)
			sample_o <= pwdata_i[17:0];
	end

	always_comb begin
		prdata_o = '0; // control bits read back as zero, so do unmapped addresses
		if (is_status)
			prdata_o = {31'b0, busy_i};
		else if (is_sample)
			prdata_o = {{14{sample_o[17]}}, sample_o};
	end

	assert property (@(posedge clk_i) disable iff (harmonics_rst)
		penable_i |-> $past(psel_i && !penable_i))
		else $error("APB access phase without a setup phase");

endmodule

//--- verilog/harmonic_sequencer.sv
`timescale 1ns/1ps

module harmonic_sequencer (
	input logic clk_i,
	input logic harmonics_rst,
	input logic start_i,
	input logic clear_i,
	output logic busy_o,
	output kalman_pkg::coef_addr_t coef_raddr_o,
	output kalman_pkg::state_addr_t state_raddr_o,
	input kalman_pkg::sample_t coef_rdata_i,
	input kalman_pkg::sample_t state_rdata_i,
	input logic err_valid_i,
	input kalman_pkg::sample_t err_i,
	output logic op_valid_o,
	output kalman_pkg::sample_t op_a0_o,
	output kalman_pkg::sample_t op_b0_o,
	output kalman_pkg::sample_t op_a1_o,
	output kalman_pkg::sample_t op_b1_o,
	output kalman_pkg::sample_t op_addend_o,
	output logic op_sub_o,
	output logic [kalman_pkg::STATE_ADDR_WIDTH:0] op_tag_o,
	output logic clr_we_o,
	output kalman_pkg::state_addr_t clr_addr_o,
	input logic res_valid_i
);

	kalman_pkg::seq_state_e state_q;
	kalman_pkg::harm_idx_t harm_q;
	logic step_q; // which half of a read or issue pair
	logic last_harm;
	kalman_pkg::state_addr_t cur_addr;
	kalman_pkg::sample_t coef_d1;
	kalman_pkg::sample_t coef_d2;
	kalman_pkg::sample_t state_d1;
	kalman_pkg::sample_t state_d2;
	kalman_pkg::sample_t err_q;

	function automatic kalman_pkg::coef_addr_t coef_addr(input kalman_pkg::harm_idx_t h,
			input int off);
		return kalman_pkg::coef_addr_t'(int'(h) * kalman_pkg::COEF_PER_HARM + off);
	endfunction

	function automatic kalman_pkg::state_addr_t state_addr(input kalman_pkg::harm_idx_t h,
			input int off);
		return kalman_pkg::state_addr_t'(int'(h) * kalman_pkg::STATE_PER_HARM + off);
	endfunction

	assign last_harm = harm_q == kalman_pkg::harm_idx_t'(kalman_pkg::HARMONICS_NUM - 1);
	assign busy_o = state_q != kalman_pkg::IDLE;
	assign cur_addr = state_addr(harm_q, step_q ? kalman_pkg::STATE_X2 : kalman_pkg::STATE_X1);

	always_ff @(posedge clk_i) begin
		if (harmonics_rst) begin
			state_q <= kalman_pkg::IDLE;
			harm_q <= '0;
			step_q <= 1'b0;
		end else begin
			step_q <= 1'b0;
			case (state_q)
				kalman_pkg::IDLE: begin
					if (start_i)
						state_q <= kalman_pkg::PRED_RD;
					else if (clear_i)
						state_q <= kalman_pkg::CLEAR;
				end
				kalman_pkg::PRED_RD, kalman_pkg::CORR_RD: begin
					step_q <= ~step_q;
					if (step_q)
						state_q <= (state_q == kalman_pkg::PRED_RD) ?
							kalman_pkg::PRED_WAIT : kalman_pkg::CORR_WAIT;
				end
				kalman_pkg::PRED_WAIT: begin
					step_q <= ~step_q;
					if (step_q) begin
						harm_q <= last_harm ? '0 : harm_q + 1'b1;
						state_q <= last_harm ? kalman_pkg::ERR_WAIT : kalman_pkg::PRED_RD;
					end
				end
				kalman_pkg::ERR_WAIT: begin
					if (err_valid_i)
						state_q <= kalman_pkg::CORR_RD;
				end
				kalman_pkg::CORR_WAIT: begin
					step_q <= ~step_q;
					if (step_q) begin
						harm_q <= last_harm ? '0 : harm_q + 1'b1;
						state_q <= last_harm ? kalman_pkg::DONE : kalman_pkg::CORR_RD;
					end
				end
				kalman_pkg::CLEAR: begin
					step_q <= ~step_q;
					if (step_q) begin
						harm_q <= last_harm ? '0 : harm_q + 1'b1;
						if (last_harm)
							state_q <= kalman_pkg::IDLE;
					end
				end
				default: begin
					if (!res_valid_i) // stay until the MAC has drained
						state_q <= kalman_pkg::IDLE;
				end
			endcase
		end
	end

	// two deep history of the RAM outputs so both ops of a pair see their operands
	always_ff @(posedge clk_i) begin
		coef_d1 <= coef_rdata_i;
		coef_d2 <= coef_d1;
		state_d1 <= state_rdata_i;
		state_d2 <= state_d1;
		if (err_valid_i)
			err_q <= err_i;
	end

	always_comb begin
		if (state_q == kalman_pkg::CORR_RD)
			coef_raddr_o = coef_addr(harm_q, step_q ? kalman_pkg::COEF_K2 : kalman_pkg::COEF_K1);
		else
			coef_raddr_o = coef_addr(harm_q, step_q ? kalman_pkg::COEF_SIN : kalman_pkg::COEF_COS);
	end

	assign state_raddr_o = cur_addr;
	assign clr_we_o = state_q == kalman_pkg::CLEAR;
	assign clr_addr_o = cur_addr;

	always_comb begin
		op_valid_o = 1'b0;
		op_a0_o = coef_d1;
		op_b0_o = state_d1;
		op_a1_o = '0;
		op_b1_o = '0;
		op_addend_o = '0;
		op_sub_o = 1'b0;
		op_tag_o = {1'b0, cur_addr};
		case (state_q)
			kalman_pkg::PRED_WAIT: begin
				op_valid_o = 1'b1;
				if (!step_q) begin // a = cos*x1 - sin*x2 with sin and x2 still on the RAM outputs
					op_a1_o = coef_rdata_i;
					op_b1_o = state_rdata_i;
					op_sub_o = 1'b1;
					op_tag_o = {1'b1, cur_addr};
				end else begin // x2p = sin*x1 + cos*x2
					op_b0_o = state_d2;
					op_a1_o = coef_d2;
					op_b1_o = state_d1;
				end
			end
			kalman_pkg::CORR_WAIT: begin
				op_valid_o = 1'b1; // x + k*err, second product left at zero
				op_b0_o = err_q;
				op_addend_o = state_d1;
			end
			default: ;
		endcase
	end

	// the APB side refuses control writes during a run
	assert property (@(posedge clk_i) disable iff (harmonics_rst) start_i |-> !busy_o)
		else $error("start arrived while busy");

endmodule

//--- verilog/mac_unit.sv
`timescale 1ns/1ps

module mac_unit (
	input logic clk_i,
	input logic harmonics_rst,
	input logic op_valid_i,
	input kalman_pkg::sample_t op_a0_i,
	input kalman_pkg::sample_t op_b0_i,
	input kalman_pkg::sample_t op_a1_i,
	input kalman_pkg::sample_t op_b1_i,
	input kalman_pkg::sample_t op_addend_i,
	input logic op_sub_i,
	input logic [kalman_pkg::STATE_ADDR_WIDTH:0] op_tag_i,
	output logic res_valid_o,
	output kalman_pkg::sample_t res_o,
	output logic [kalman_pkg::STATE_ADDR_WIDTH:0] res_tag_o
);

	logic valid_q;
	kalman_pkg::product_t prod0_q;
	kalman_pkg::product_t prod1_q;
	kalman_pkg::sample_t addend_q;
	logic sub_q;
	logic [kalman_pkg::STATE_ADDR_WIDTH:0] tag_q;
	kalman_pkg::sample_t term0;
	kalman_pkg::sample_t term1;

	always_ff @(posedge clk_i) begin
		if (harmonics_rst) begin
			valid_q <= 1'b0;
			res_valid_o <= 1'b0;
		end else begin
			valid_q <= op_valid_i;
			res_valid_o <= valid_q;
		end
	end

	// stage one keeps the full 36-bit signed products
	always_ff @(posedge clk_i) begin
		prod0_q <= op_a0_i * op_b0_i;
		prod1_q <= op_a1_i * op_b1_i;
		addend_q <= op_addend_i;
		sub_q <= op_sub_i;
		tag_q <= op_tag_i;
	end

	assign term0 = kalman_pkg::sample_t'(prod0_q >>> kalman_pkg::Q_FRAC_BITS);
	assign term1 = kalman_pkg::sample_t'(prod1_q >>> kalman_pkg::Q_FRAC_BITS);

	always_ff @(posedge clk_i) begin
		res_o <= sub_q ? addend_q + term0 - term1 : addend_q + term0 + term1; // wraps at 18 bits
		res_tag_o <= tag_q;
	end

	// an unknown operand means a state was read before any clear pass
	assert property (@(posedge clk_i) disable iff (harmonics_rst)
		op_valid_i |-> !$isunknown({op_a0_i, op_b0_i, op_a1_i, op_b1_i, op_addend_i}))
		else $error("MAC operand unknown at issue");

endmodule

//--- verilog/estimate_out.sv
`timescale 1ns/1ps

module estimate_out (
	input logic clk_i,
	input logic harmonics_rst,
	input kalman_pkg::sample_t sample_i,
	input logic res_valid_i,
	input kalman_pkg::sample_t res_i,
	input logic [kalman_pkg::STATE_ADDR_WIDTH:0] res_tag_i,
	input logic clr_we_i,
	input kalman_pkg::state_addr_t clr_addr_i,
	output logic err_valid_o,
	output kalman_pkg::sample_t err_o,
	output logic state_we_o,
	output kalman_pkg::state_addr_t state_addr_o,
	output kalman_pkg::sample_t state_data_o,
	output kalman_pkg::sample_t estimate_o,
	output kalman_pkg::sample_t error_o,
	output logic sample_done_o
);

	kalman_pkg::sample_t acc_q;
	kalman_pkg::sample_t sum;
	kalman_pkg::harm_idx_t cnt_q;
	kalman_pkg::state_addr_t res_addr;
	logic pred_x1;
	logic last_pred;
	logic corr_q; // set once the error went out, the next writes are corrections

	assign res_addr = res_tag_i[kalman_pkg::STATE_ADDR_WIDTH-1:0];
	assign pred_x1 = res_valid_i & res_tag_i[kalman_pkg::STATE_ADDR_WIDTH];
	assign last_pred = pred_x1 && (cnt_q == kalman_pkg::harm_idx_t'(kalman_pkg::HARMONICS_NUM - 1));
	assign sum = acc_q + res_i;

	always_ff @(posedge clk_i) begin
		if (harmonics_rst) begin
			acc_q <= '0;
			cnt_q <= '0;
			err_valid_o <= 1'b0;
			corr_q <= 1'b0;
			sample_done_o <= 1'b0;
		end else begin
			err_valid_o <= last_pred;
			sample_done_o <= 1'b0;
			if (pred_x1) begin
				acc_q <= last_pred ? '0 : sum; // cleared for the next sample
				cnt_q <= last_pred ? '0 : cnt_q + 1'b1;
			end
			// the last prediction x2 write lands while err_valid is high, one cycle before corr_q
			if (err_valid_o)
				corr_q <= 1'b1;
			if (corr_q && res_valid_i && res_addr == kalman_pkg::state_addr_t'(
					kalman_pkg::HARMONICS_NUM * kalman_pkg::STATE_PER_HARM - 1)) begin
				corr_q <= 1'b0;
				sample_done_o <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (last_pred) begin
			estimate_o <= sum;
			error_o <= sample_i - sum;
		end
	end

	assign err_o = error_o;

	// clear writes and MAC results never overlap
	assign state_we_o = res_valid_i | clr_we_i;
	assign state_addr_o = clr_we_i ? clr_addr_i : res_addr;
	assign state_data_o = clr_we_i ? '0 : res_i;

endmodule

//--- verilog/kalman_harmonic_top.sv
`timescale 1ns/1ps

module kalman_harmonic_top (
	input logic clk_i,
	input logic harmonics_rst,
	input logic psel_i,
	input logic penable_i,
	input logic pwrite_i,
	input kalman_pkg::apb_addr_t paddr_i,
	input logic [31:0] pwdata_i,
	output logic [31:0] prdata_o,
	output logic pready_o,
	output logic pslverr_o,
	output logic state_we_o,
	output kalman_pkg::state_addr_t state_addr_o,
	output kalman_pkg::sample_t state_data_o,
	output kalman_pkg::sample_t estimate_o,
	output kalman_pkg::sample_t error_o,
	output logic sample_done_o
);

	logic coef_we;
	kalman_pkg::coef_addr_t coef_waddr;
	kalman_pkg::sample_t coef_wdata;
	kalman_pkg::sample_t sample;
	logic start;
	logic clear;
	logic busy;
	kalman_pkg::coef_addr_t coef_raddr;
	kalman_pkg::sample_t coef_rdata;
	kalman_pkg::state_addr_t state_raddr;
	kalman_pkg::sample_t state_rdata;
	logic err_valid;
	kalman_pkg::sample_t err;
	logic op_valid;
	kalman_pkg::sample_t op_a0;
	kalman_pkg::sample_t op_b0;
	kalman_pkg::sample_t op_a1;
	kalman_pkg::sample_t op_b1;
	kalman_pkg::sample_t op_addend;
	logic op_sub;
	logic [kalman_pkg::STATE_ADDR_WIDTH:0] op_tag;
	logic clr_we;
	kalman_pkg::state_addr_t clr_addr;
	logic res_valid;
	kalman_pkg::sample_t res;
	logic [kalman_pkg::STATE_ADDR_WIDTH:0] res_tag;

	apb_host_port u_apb (
		.clk_i(clk_i), .harmonics_rst(harmonics_rst),
		.psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
		.paddr_i(paddr_i), .pwdata_i(pwdata_i), .prdata_o(prdata_o),
		.pready_o(pready_o), .pslverr_o(pslverr_o), .busy_i(busy),
		.coef_we_o(coef_we), .coef_waddr_o(coef_waddr), .coef_wdata_o(coef_wdata),
		.sample_o(sample), .start_o(start), .clear_o(clear)
	);

	dp_ram #(
		.DEPTH(kalman_pkg::HARMONICS_NUM * kalman_pkg::COEF_PER_HARM),
		.WIDTH(18)
	) u_coef_ram (
		.clk_i(clk_i), .we_i(coef_we), .waddr_i(coef_waddr), .wdata_i(coef_wdata),
		.raddr_i(coef_raddr), .rdata_o(coef_rdata)
	);

	// state writes come back from the output side, MAC results and clears alike
	dp_ram #(
		.DEPTH(kalman_pkg::HARMONICS_NUM * kalman_pkg::STATE_PER_HARM),
		.WIDTH(18)
	) u_state_ram (
		.clk_i(clk_i), .we_i(state_we_o), .waddr_i(state_addr_o), .wdata_i(state_data_o),
		.raddr_i(state_raddr), .rdata_o(state_rdata)
	);

	harmonic_sequencer u_seq (
		.clk_i(clk_i), .harmonics_rst(harmonics_rst),
		.start_i(start), .clear_i(clear), .busy_o(busy),
		.coef_raddr_o(coef_raddr), .state_raddr_o(state_raddr),
		.coef_rdata_i(coef_rdata), .state_rdata_i(state_rdata),
		.err_valid_i(err_valid), .err_i(err),
		.op_valid_o(op_valid), .op_a0_o(op_a0), .op_b0_o(op_b0),
		.op_a1_o(op_a1), .op_b1_o(op_b1), .op_addend_o(op_addend),
		.op_sub_o(op_sub), .op_tag_o(op_tag),
		.clr_we_o(clr_we), .clr_addr_o(clr_addr), .res_valid_i(res_valid)
	);

	mac_unit u_mac (
		.clk_i(clk_i), .harmonics_rst(harmonics_rst),
		.op_valid_i(op_valid), .op_a0_i(op_a0), .op_b0_i(op_b0),
		.op_a1_i(op_a1), .op_b1_i(op_b1), .op_addend_i(op_addend),
		.op_sub_i(op_sub), .op_tag_i(op_tag),
		.res_valid_o(res_valid), .res_o(res), .res_tag_o(res_tag)
	);

	estimate_out u_est (
		.clk_i(clk_i), .harmonics_rst(harmonics_rst), .sample_i(sample),
		.res_valid_i(res_valid), .res_i(res), .res_tag_i(res_tag),
		.clr_we_i(clr_we), .clr_addr_i(clr_addr),
		.err_valid_o(err_valid), .err_o(err),
		.state_we_o(state_we_o), .state_addr_o(state_addr_o), .state_data_o(state_data_o),
		.estimate_o(estimate_o), .error_o(error_o), .sample_done_o(sample_done_o)
	);

endmodule

//--- tests/kalman_ref_model.svh
`ifndef KALMAN_REF_MODEL_SVH
`define KALMAN_REF_MODEL_SVH

// coefficients as the host last wrote them, indexed by harmonic and offset
kalman_pkg::sample_t m_coef [kalman_pkg::HARMONICS_NUM][kalman_pkg::COEF_PER_HARM];
kalman_pkg::sample_t m_x1 [kalman_pkg::HARMONICS_NUM];
kalman_pkg::sample_t m_x2 [kalman_pkg::HARMONICS_NUM];

// state writes still expected on the output stream, oldest first
kalman_pkg::state_addr_t exp_addr_q [$];
kalman_pkg::sample_t exp_data_q [$];
kalman_pkg::sample_t exp_estimate;
kalman_pkg::sample_t exp_error;

function automatic kalman_pkg::sample_t q_mul(input kalman_pkg::sample_t a,
		input kalman_pkg::sample_t b);
	logic signed [35:0] wide_a;
	logic signed [35:0] wide_b;
	logic signed [35:0] prod;
	wide_a = a;
	wide_b = b;
	prod = wide_a * wide_b;
	return prod[33:16]; // shift right by the 16 fraction bits and keep 18 bits
endfunction

function automatic void push_write(input int addr, input kalman_pkg::sample_t data);
	exp_addr_q.push_back(kalman_pkg::state_addr_t'(addr));
	exp_data_q.push_back(data);
endfunction

function automatic void model_clear();
	for (int h = 0; h < kalman_pkg::HARMONICS_NUM; h++) begin
		m_x1[h] = '0;
		m_x2[h] = '0;
		push_write(2 * h, '0);
		push_write(2 * h + 1, '0);
	end
endfunction

function automatic void model_run(input kalman_pkg::sample_t s);
	kalman_pkg::sample_t a [kalman_pkg::HARMONICS_NUM];
	kalman_pkg::sample_t x2p [kalman_pkg::HARMONICS_NUM];
	kalman_pkg::sample_t est;
	kalman_pkg::sample_t err;
	est = '0;
	for (int h = 0; h < kalman_pkg::HARMONICS_NUM; h++) begin
		a[h] = q_mul(m_coef[h][0], m_x1[h]) - q_mul(m_coef[h][1], m_x2[h]);
		x2p[h] = q_mul(m_coef[h][1], m_x1[h]) + q_mul(m_coef[h][0], m_x2[h]);
		est = est + a[h]; // wraps at 18 bits like every sum here
		push_write(2 * h, a[h]);
		push_write(2 * h + 1, x2p[h]);
	end
	err = s - est;
	// correction pass uses the gains at offsets 2 and 3
	for (int h = 0; h < kalman_pkg::HARMONICS_NUM; h++) begin
		m_x1[h] = a[h] + q_mul(m_coef[h][2], err);
		m_x2[h] = x2p[h] + q_mul(m_coef[h][3], err);
		push_write(2 * h, m_x1[h]);
		push_write(2 * h + 1, m_x2[h]);
	end
	exp_estimate = est;
	exp_error = err;
endfunction

`endif

//--- tests/tb_kalman_harmonic.sv
`timescale 1ns/1ps

module tb_kalman_harmonic;

	localparam int NUM_SAMPLES = 30;
	localparam int NUM_OPS = NUM_SAMPLES + 4; // reset, coefficient load, clear and map checks
	localparam int CYCLE_LIMIT = 400 * NUM_OPS;
	localparam int COEF_MAX = 64880; // 0.99 in Q2.16

	logic clk_i;
	logic harmonics_rst;
	logic psel_i;
	logic penable_i;
	logic pwrite_i;
	kalman_pkg::apb_addr_t paddr_i;
	logic [31:0] pwdata_i;
	logic [31:0] prdata_o;
	logic pready_o;
	logic pslverr_o;
	logic state_we_o;
	kalman_pkg::state_addr_t state_addr_o;
	kalman_pkg::sample_t state_data_o;
	kalman_pkg::sample_t estimate_o;
	kalman_pkg::sample_t error_o;
	logic sample_done_o;

	int error_count = 0;
	int check_count = 0;
	int done_count = 0;
	int cycle_count = 0;

	`include "kalman_ref_model.svh"

	kalman_harmonic_top UUT (
		.clk_i(clk_i), .harmonics_rst(harmonics_rst),
		.psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
		.paddr_i(paddr_i), .pwdata_i(pwdata_i), .prdata_o(prdata_o),
		.pready_o(pready_o), .pslverr_o(pslverr_o),
		.state_we_o(state_we_o), .state_addr_o(state_addr_o), .state_data_o(state_data_o),
		.estimate_o(estimate_o), .error_o(error_o), .sample_done_o(sample_done_o)
	);

	always #20 clk_i = ~clk_i;

	task automatic check_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
		check_count++;
		assert (got === exp) else begin
			error_count++;
			$display("CHECK FAILED at %0t ns: %s expected %0d got %0d", $time, name,
				$signed(exp), $signed(got));
		end
	endtask

	function automatic logic [31:0] widen(input kalman_pkg::sample_t v);
		logic signed [31:0] w;
		w = v; // sign extends
		return w;
	endfunction

	// two cycle APB transfer, outputs sampled mid access phase
	task automatic apb_transfer(input logic write, input kalman_pkg::apb_addr_t addr,
			input logic [31:0] wdata, output logic [31:0] rdata, output logic slverr);
		@(posedge clk_i);
		#2;
		psel_i = 1'b1;
		penable_i = 1'b0;
		pwrite_i = write;
		paddr_i = addr;
		pwdata_i = wdata;
		@(posedge clk_i);
		#2;
		penable_i = 1'b1;
		@(negedge clk_i);
		rdata = prdata_o;
		slverr = pslverr_o;
		check_equal("pready_o", pready_o, 32'h1); // no wait states on this slave
		@(posedge clk_i);
		#2;
		psel_i = 1'b0;
		penable_i = 1'b0;
		pwrite_i = 1'b0;
	endtask

	task automatic reg_write(input kalman_pkg::apb_addr_t addr, input logic [31:0] data,
			input logic exp_err);
		logic [31:0] rdata;
		logic slverr;
		apb_transfer(1'b1, addr, data, rdata, slverr);
		check_equal($sformatf("pslverr_o on write to 0x%02h", addr), slverr, exp_err);
	endtask

	task automatic reg_read(input kalman_pkg::apb_addr_t addr, output logic [31:0] data,
			input logic exp_err);
		logic slverr;
		apb_transfer(1'b0, addr, '0, data, slverr);
		check_equal($sformatf("pslverr_o on read of 0x%02h", addr), slverr, exp_err);
	endtask

	task automatic wait_idle();
		logic [31:0] status;
		logic slverr;
		status = 32'h1;
		while (status[0]) begin
			apb_transfer(1'b0, kalman_pkg::REG_STATUS, '0, status, slverr);
		end
	endtask

	task automatic load_coefs();
		kalman_pkg::sample_t val;
		for (int h = 0; h < kalman_pkg::HARMONICS_NUM; h++) begin
			for (int off = 0; off < kalman_pkg::COEF_PER_HARM; off++) begin
				val = kalman_pkg::sample_t'(int'($urandom_range(2 * COEF_MAX, 0)) - COEF_MAX);
				m_coef[h][off] = val;
				reg_write(kalman_pkg::apb_addr_t'(kalman_pkg::COEF_BASE
					+ 4 * (kalman_pkg::COEF_PER_HARM * h + off)), widen(val), 1'b0);
			end
		end
	endtask

	task automatic check_map();
		kalman_pkg::apb_addr_t holes [4] = '{8'h0C, 8'h20, 8'h42, 8'h80};
		logic [31:0] rdata;
		foreach (holes[i]) begin
			reg_read(holes[i], rdata, 1'b1);
			check_equal("prdata_o of unmapped read", rdata, 32'h0);
		end
		reg_write(8'h20, 32'h1, 1'b1);
		reg_read(kalman_pkg::REG_STATUS, rdata, 1'b0);
		check_equal("status while idle", rdata, 32'h0);
	endtask

	task automatic run_sample(input kalman_pkg::sample_t s, input logic probe_busy);
		int start_done;
		logic [31:0] rdata;
		reg_write(kalman_pkg::REG_SAMPLE, widen(s), 1'b0);
		model_run(s);
		start_done = done_count;
		reg_write(kalman_pkg::REG_CTRL, 32'h1, 1'b0);
		if (probe_busy) begin
			reg_read(kalman_pkg::REG_STATUS, rdata, 1'b0);
			check_equal("status during run", rdata, 32'h1);
			// each of these would corrupt the run if it got through
			reg_write(kalman_pkg::COEF_BASE, widen(~m_coef[0][0]), 1'b1);
			reg_write(kalman_pkg::REG_SAMPLE, widen(~s), 1'b1);
			reg_write(kalman_pkg::REG_CTRL, 32'h2, 1'b1);
			reg_read(kalman_pkg::REG_SAMPLE, rdata, 1'b0);
			check_equal("sample register after refused write", rdata, widen(s));
		end
		while (done_count == start_done) @(posedge clk_i);
		wait_idle();
		reg_read(kalman_pkg::REG_STATUS, rdata, 1'b0);
		check_equal("status after run", rdata, 32'h0);
		check_equal("state writes left over", exp_addr_q.size(), 0);
	endtask

	// state stream and per sample results, compared in order against the model
	always @(negedge clk_i) begin
		if (!harmonics_rst && state_we_o) begin
			if (exp_addr_q.size() == 0) begin
				error_count++;
				$display("unexpected state write to address %0d at %0t ns", state_addr_o, $time);
			end else begin
				check_equal("state_addr_o", state_addr_o, exp_addr_q.pop_front());
				check_equal("state_data_o", state_data_o, exp_data_q.pop_front());
			end
		end
		if (!harmonics_rst && sample_done_o) begin
			done_count++;
			check_equal("estimate_o", estimate_o, exp_estimate);
			check_equal("error_o", error_o, exp_error);
		end
	end

	initial begin
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clk_i);
			cycle_count++;
		end
		error_count++;
		$display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("checks %0d, errors %0d", check_count, error_count);
		$display("tests failed");
		$finish;
	end

	initial begin
		clk_i = 1'b0;
		harmonics_rst = 1'b1;
		psel_i = 1'b0;
		penable_i = 1'b0;
		pwrite_i = 1'b0;
		paddr_i = '0;
		pwdata_i = '0;
		void'($urandom(32'he5c0c336));
		repeat (16) @(posedge clk_i);
		#2;
		harmonics_rst = 1'b0;
		@(negedge clk_i);
		check_equal("state_we_o after reset", state_we_o, 32'h0);
		check_equal("sample_done_o after reset", sample_done_o, 32'h0);
		check_equal("pslverr_o after reset", pslverr_o, 32'h0);
		load_coefs();
		model_clear(); // states hold X until this pass zeroes them
		reg_write(kalman_pkg::REG_CTRL, 32'h2, 1'b0);
		wait_idle();
		check_equal("clear writes left over", exp_addr_q.size(), 0);
		check_map();
		for (int i = 0; i < NUM_SAMPLES; i++) begin
			run_sample(kalman_pkg::sample_t'($urandom), i == 0);
		end
		$display("checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

//--- files.f
+incdir+tests
verilog/kalman_pkg.sv
verilog/dp_ram.sv
verilog/apb_host_port.sv
verilog/harmonic_sequencer.sv
verilog/mac_unit.sv
verilog/estimate_out.sv
verilog/kalman_harmonic_top.sv
tests/tb_kalman_harmonic.sv
